// ==== all.f ====
common/backend_pkg.sv
src/uop_decode.sv
src/uop_execute.sv
writeback/writeback_stage.sv
writeback/arch_reg_file.sv
src/backend_top.sv
bench/backend_props.sv
bench/tb_backend.sv

// ==== bench/backend_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module backend_props (
    input wire logic clk,
    input wire logic reset,
    input wire logic valid_out,
    input wire logic stall,
    input wire logic reg_ld,
    input wire logic seg_ld,
    input wire logic mem_ld,
    input wire logic is_resteer
);

    // store queue backpressure blocks every write
    assert property (@(posedge clk) disable iff (reset) stall |-> !(reg_ld || seg_ld || mem_ld))
        else $error("write strobe high while stall is high");

    assert property (@(posedge clk) disable iff (reset) is_resteer |-> valid_out)
        else $error("is_resteer without valid_out");

    assert property (@(posedge clk) disable iff (reset) $onehot0({reg_ld, seg_ld, mem_ld}))
        else $error("more than one write strobe set");

endmodule

// writeback outputs, sampled on the top clock
bind backend_top backend_props u_backend_props (
    .clk        (clk),
    .reset      (reset),
    .valid_out  (valid_out),
    .stall      (stall),
    .reg_ld     (reg_ld),
    .seg_ld     (seg_ld),
    .mem_ld     (mem_ld),
    .is_resteer (is_resteer)
);

`default_nettype wire

// ==== bench/tb_backend.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_backend;

    localparam int uop_per_test = 120;
    localparam int random_tests = 6;
    localparam int cycle_limit  = 12 * uop_per_test * random_tests + 100;

    logic        clk = 1'b0;
    logic        reset;
    logic        in_valid;
    logic [15:0] in_uop;
    logic [31:0] in_eip;
    logic        wbaq_full;
    logic        interrupt_in;

    logic        in_ready;
    logic        reg_ld;
    logic [2:0]  reg_addr;
    logic        seg_ld;
    logic [2:0]  seg_addr;
    logic [31:0] res;
    logic        mem_ld;
    logic [31:0] mem_addr;
    logic [31:0] mem_data;
    logic [31:0] new_eip;
    logic        is_resteer;
    logic        stall;
    logic        valid_out;
    logic        final_ie_val;
    logic [3:0]  final_ie_type;

    logic [31:0] lfsr = 32'hdbe9_aa5f;
    logic [31:0] model_gpr [8];
    logic [15:0] q_uop [$];     // accepted ops, oldest first
    logic [31:0] q_eip [$];
    int          q_age [$];     // edges passed since acceptance
    logic [2:0]  last_dst;
    int          err_count = 0;
    int          failed_tests = 0;
    int          cycle_count;
    int          accepted;
    int          retired;
    int          flushed;
    int          stalls;
    int          ie_seen;

    always #4 clk = ~clk;

    backend_top u_backend_top (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_uop        (in_uop),
        .in_eip        (in_eip),
        .wbaq_full     (wbaq_full),
        .interrupt_in  (interrupt_in),
        .in_ready      (in_ready),
        .reg_ld        (reg_ld),
        .reg_addr      (reg_addr),
        .seg_ld        (seg_ld),
        .seg_addr      (seg_addr),
        .res           (res),
        .mem_ld        (mem_ld),
        .mem_addr      (mem_addr),
        .mem_data      (mem_data),
        .new_eip       (new_eip),
        .is_resteer    (is_resteer),
        .stall         (stall),
        .valid_out     (valid_out),
        .final_ie_val  (final_ie_val),
        .final_ie_type (final_ie_type)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [3:0] pick_opcode(input int t);
        logic [31:0] r;
        r = rand_bits(4);
        case (t)
            0: return {2'b00, r[1:0]};
            1: return r[0] ? backend_pkg::op_mov_seg : {2'b00, r[2:1]};
            2: return r[0] ? backend_pkg::op_store : {2'b00, r[2:1]};
            3: begin
                if (r[1:0] == 2'b00) return backend_pkg::op_jmp;
                else if (r[1:0] == 2'b01) return backend_pkg::op_store;
                else return {2'b00, r[3:2]};
            end
            4: return r[3:0];       // mostly undefined opcodes
            default: return {1'b0, r[2:0]};
        endcase
    endfunction

    function automatic string test_label(input int t);
        case (t)
            0: return "alu";
            1: return "segment";
            2: return "store";
            3: return "jump";
            4: return "exception";
            default: return "mixed";
        endcase
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        err_count++;
    endtask

    task automatic drive_inputs(input int t, input bit allow_new);
        logic [31:0] r;
        logic [11:0] fields;
        logic [3:0]  op;
        op = pick_opcode(t);
        r = rand_bits(12);
        fields = r[11:0];
        r = rand_bits(2);
        if (r[0]) fields[8:6] = last_dst;       // read the op just before
        if (r[1]) fields[5:3] = last_dst;
        in_uop = {op, fields};
        in_eip = rand_bits(32);
        r = rand_bits(2);
        in_valid = allow_new && (r[1:0] != 2'b00);
        if (in_valid) last_dst = fields[11:9];
        r = rand_bits(2);
        wbaq_full = (t == 2 || t == 3 || t == 5) ? r[0] : 1'b0;
        interrupt_in = (t == 4 || t == 5) ? (r[1:0] == 2'b11) : 1'b0;
    endtask

    task automatic check_and_update();
        logic [15:0] w;
        logic [3:0]  op;
        logic [2:0]  dst;
        logic [2:0]  sa;
        logic [2:0]  sb;
        logic [31:0] disp_ext;
        logic [31:0] exp_val;
        logic [3:0]  exp_type;
        bit          head_wb;
        bit          exp_stall;
        bit          exp_valid;
        bit          exp_reg;
        bit          exp_seg;
        bit          exp_mem;
        bit          exp_jmp;
        bit          exp_undef;
        head_wb = q_uop.size() > 0 && q_age[0] >= 2;
        w = head_wb ? q_uop[0] : 16'h0;
        op = w[15:12];
        dst = w[11:9];
        sa = w[8:6];
        sb = w[5:3];
        disp_ext = {{20{w[11]}}, w[11:0]};
        exp_stall = head_wb && op == backend_pkg::op_store && wbaq_full;
        exp_valid = head_wb && !exp_stall;
        exp_reg = exp_valid && (op == backend_pkg::op_add || op == backend_pkg::op_sub ||
                                op == backend_pkg::op_and || op == backend_pkg::op_xor);
        exp_seg = exp_valid && op == backend_pkg::op_mov_seg && dst < 3'd6;
        exp_mem = exp_valid && op == backend_pkg::op_store;
        exp_jmp = exp_valid && op == backend_pkg::op_jmp;
        exp_undef = exp_valid && !exp_reg && !exp_seg && !exp_mem && !exp_jmp;
        case (op)
            backend_pkg::op_add:     exp_val = model_gpr[sa] + model_gpr[sb];
            backend_pkg::op_sub:     exp_val = model_gpr[sa] - model_gpr[sb];
            backend_pkg::op_and:     exp_val = model_gpr[sa] & model_gpr[sb];
            backend_pkg::op_xor:     exp_val = model_gpr[sa] ^ model_gpr[sb];
            backend_pkg::op_mov_seg: exp_val = {16'h0, model_gpr[sa][15:0]};
            default:                 exp_val = 32'h0;
        endcase
        exp_type = {interrupt_in, exp_undef ? backend_pkg::ie_undef_op[2:0] : 3'd0};

        if (stall !== exp_stall) report_mismatch($sformatf("stall expected %0b", exp_stall));
        if (in_ready !== !exp_stall) report_mismatch($sformatf("in_ready got %0b", in_ready));
        if (valid_out !== exp_valid) report_mismatch($sformatf("valid_out got %0b", valid_out));
        if (reg_ld !== exp_reg) report_mismatch($sformatf("reg_ld expected %0b", exp_reg));
        if (seg_ld !== exp_seg) report_mismatch($sformatf("seg_ld expected %0b", exp_seg));
        if (mem_ld !== exp_mem) report_mismatch($sformatf("mem_ld expected %0b", exp_mem));
        if (is_resteer !== exp_jmp) report_mismatch($sformatf("is_resteer got %0b", is_resteer));
        if (final_ie_val !== (exp_undef || interrupt_in)) begin
            report_mismatch($sformatf("final_ie_val got %0b", final_ie_val));
        end
        if (final_ie_type !== exp_type) begin
            report_mismatch($sformatf("final_ie_type expected %0h got %0h",
                                      exp_type, final_ie_type));
        end
        if (exp_reg && reg_addr !== dst) report_mismatch($sformatf("reg_addr expected %0d", dst));
        if (exp_reg && res !== exp_val) begin
            report_mismatch($sformatf("res expected %0h got %0h", exp_val, res));
        end
        if (exp_seg && seg_addr !== dst) report_mismatch($sformatf("seg_addr expected %0d", dst));
        if (exp_seg && res !== exp_val) begin
            report_mismatch($sformatf("seg res expected %0h", exp_val));
        end
        if (exp_mem && mem_addr !== model_gpr[sa]) begin
            report_mismatch($sformatf("mem_addr expected %0h got %0h", model_gpr[sa], mem_addr));
        end
        if (exp_mem && mem_data !== model_gpr[sb]) begin
            report_mismatch($sformatf("mem_data expected %0h got %0h", model_gpr[sb], mem_data));
        end
        if (exp_jmp && new_eip !== q_eip[0] + disp_ext) begin
            report_mismatch($sformatf("new_eip expected %0h got %0h",
                                      q_eip[0] + disp_ext, new_eip));
        end

        if (exp_reg) model_gpr[dst] = exp_val;
        if (exp_stall) stalls++;
        if (exp_undef) ie_seen++;
        if (exp_valid) begin
            retired++;
            void'(q_uop.pop_front());
            void'(q_eip.pop_front());
            void'(q_age.pop_front());
        end
        if (in_valid && !exp_stall) accepted++;
        if (exp_jmp) begin
            flushed += q_uop.size() + (in_valid ? 1 : 0);   // younger ops and this edge's op
            q_uop.delete();
            q_eip.delete();
            q_age.delete();
        end else if (!exp_stall) begin
            for (int i = 0; i < q_age.size(); i++) q_age[i] = q_age[i] + 1;
            if (in_valid) begin
                q_uop.push_back(in_uop);
                q_eip.push_back(in_eip);
                q_age.push_back(1);
            end
        end
    endtask

    task automatic step_cycle(input int t, input bit allow_new);
        @(posedge clk);
        #1;
        drive_inputs(t, allow_new);
        @(negedge clk);
        check_and_update();
    endtask

    task automatic run_test(input int t);
        int err_before;
        err_before = err_count;
        accepted = 0;
        retired = 0;
        flushed = 0;
        stalls = 0;
        ie_seen = 0;
        while (accepted < uop_per_test) step_cycle(t, 1'b1);
        while (q_uop.size() != 0) step_cycle(t, 1'b0);     // drain
        if (err_count != err_before) failed_tests++;
        $write("test %s: %0d accepted, %0d retired, %0d flushed, ",
               test_label(t), accepted, retired, flushed);
        $display("%0d stalls, %0d exceptions, %0d errors",
                 stalls, ie_seen, err_count - err_before);
    endtask

    task automatic check_reset_state();
        int err_before;
        err_before = err_count;
        if (valid_out !== 1'b0) report_mismatch($sformatf("valid_out after reset %0b", valid_out));
        if (stall !== 1'b0) report_mismatch($sformatf("stall after reset %0b", stall));
        if (is_resteer !== 1'b0) begin
            report_mismatch($sformatf("is_resteer after reset %0b", is_resteer));
        end
        if (reg_ld !== 1'b0) report_mismatch($sformatf("reg_ld after reset %0b", reg_ld));
        if (seg_ld !== 1'b0) report_mismatch($sformatf("seg_ld after reset %0b", seg_ld));
        if (mem_ld !== 1'b0) report_mismatch($sformatf("mem_ld after reset %0b", mem_ld));
        if (in_ready !== 1'b1) report_mismatch($sformatf("in_ready after reset %0b", in_ready));
        if (final_ie_val !== interrupt_in) begin
            report_mismatch("final_ie_val not following interrupt_in");
        end
        if (err_count != err_before) failed_tests++;
        $display("test reset: %0d errors", err_count - err_before);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_uop = 16'h0;
        in_eip = 32'h0;
        wbaq_full = 1'b0;
        interrupt_in = 1'b0;
        last_dst = 3'd0;
        for (int i = 0; i < 8; i++) model_gpr[i] = 32'h0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_reset_state();
        for (int t = 0; t < random_tests; t++) run_test(t);
        $display("summary: %0d tests, %0d failed, %0d errors",
                 random_tests + 1, failed_tests, err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== common/backend_pkg.sv ====
`default_nettype none

package backend_pkg;

    localparam int data_w    = 32;
    localparam int gpr_count = 8;
    localparam int gpr_idx_w = 3;
    localparam int seg_count = 6;
    localparam int seg_w     = 16;
    localparam int op_w      = 4;
    localparam int disp_w    = 12;

    // opcodes, 7..15 are undefined
    localparam logic [op_w-1:0] op_add     = 4'h0;
    localparam logic [op_w-1:0] op_sub     = 4'h1;
    localparam logic [op_w-1:0] op_and     = 4'h2;
    localparam logic [op_w-1:0] op_xor     = 4'h3;
    localparam logic [op_w-1:0] op_mov_seg = 4'h4;
    localparam logic [op_w-1:0] op_store   = 4'h5;
    localparam logic [op_w-1:0] op_jmp     = 4'h6;

    localparam int ie_type_w = 4;
    localparam logic [ie_type_w-1:0] ie_undef_op = 4'd6;
    localparam int ie_interrupt_bit = 3;    // set while interrupt_in is high

    typedef enum logic [2:0] {
        alu,
        seg,
        store,
        jmp,
        undef
    } op_class_t;

    // one micro-op word, read as register op or as relative jump
    typedef union packed {
        struct packed {
            logic [op_w-1:0]      opcode;
            logic [gpr_idx_w-1:0] dst;
            logic [gpr_idx_w-1:0] src_a;
            logic [gpr_idx_w-1:0] src_b;
            logic [2:0]           spare;
        } alu_view;
        struct packed {
            logic [op_w-1:0]          opcode;
            logic signed [disp_w-1:0] disp;     // from the jump's own eip
        } br_view;
    } uop_word_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile and run the backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_backend \
    -Mdir obj_dir -o tb_backend_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/tb_backend_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
    echo "failure found in sim.log"
    exit 1
fi

exit 0

// ==== src/backend_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module backend_top (
    input  wire logic                                 clk,
    input  wire logic                                 reset,
    input  wire logic                                 in_valid,
    input  wire logic [15:0]                          in_uop,
    input  wire logic [31:0]                          in_eip,
    input  wire logic                                 wbaq_full,
    input  wire logic                                 interrupt_in,
    output logic                                      in_ready,
    output logic                                      reg_ld,
    output logic [backend_pkg::gpr_idx_w-1:0]         reg_addr,
    output logic                                      seg_ld,
    output logic [backend_pkg::gpr_idx_w-1:0]         seg_addr,
    output logic [backend_pkg::data_w-1:0]            res,
    output logic                                      mem_ld,
    output logic [backend_pkg::data_w-1:0]            mem_addr,
    output logic [backend_pkg::data_w-1:0]            mem_data,
    output logic [31:0]                               new_eip,
    output logic                                      is_resteer,
    output logic                                      stall,
    output logic                                      valid_out,
    output logic                                      final_ie_val,
    output logic [backend_pkg::ie_type_w-1:0]         final_ie_type
);

    logic                                  dec_valid;
    backend_pkg::op_class_t                dec_class;
    backend_pkg::uop_word_t                dec_uop;
    logic [31:0]                           dec_eip;
    logic                                  ex_valid;
    backend_pkg::op_class_t                ex_class;
    logic [backend_pkg::gpr_idx_w-1:0]     ex_dst;
    logic [backend_pkg::data_w-1:0]        ex_result;
    logic [backend_pkg::data_w-1:0]        ex_addr;
    logic [31:0]                           ex_target;
    logic [31:0]                           ex_eip;
    logic [backend_pkg::gpr_idx_w-1:0]     rd_idx_a;
    logic [backend_pkg::gpr_idx_w-1:0]     rd_idx_b;
    logic [backend_pkg::data_w-1:0]        rd_data_a;
    logic [backend_pkg::data_w-1:0]        rd_data_b;
    logic                                  wb_fwd_en;
    logic [backend_pkg::gpr_idx_w-1:0]     wb_fwd_idx;
    logic [backend_pkg::data_w-1:0]        wb_fwd_data;

    assign in_ready = !stall;

    uop_decode u_uop_decode (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_uop    (in_uop),
        .in_eip    (in_eip),
        .stall     (stall),
        .flush     (is_resteer),
        .dec_valid (dec_valid),
        .dec_class (dec_class),
        .dec_uop   (dec_uop),
        .dec_eip   (dec_eip)
    );

    uop_execute u_uop_execute (
        .clk         (clk),
        .reset       (reset),
        .dec_valid   (dec_valid),
        .dec_class   (dec_class),
        .dec_uop     (dec_uop),
        .dec_eip     (dec_eip),
        .stall       (stall),
        .flush       (is_resteer),
        .rd_idx_a    (rd_idx_a),
        .rd_idx_b    (rd_idx_b),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .wb_fwd_en   (wb_fwd_en),
        .wb_fwd_idx  (wb_fwd_idx),
        .wb_fwd_data (wb_fwd_data),
        .ex_valid    (ex_valid),
        .ex_class    (ex_class),
        .ex_dst      (ex_dst),
        .ex_result   (ex_result),
        .ex_addr     (ex_addr),
        .ex_target   (ex_target),
        .ex_eip      (ex_eip)
    );

    writeback_stage u_writeback_stage (
        .ex_valid      (ex_valid),
        .ex_class      (ex_class),
        .ex_dst        (ex_dst),
        .ex_result     (ex_result),
        .ex_addr       (ex_addr),
        .ex_target     (ex_target),
        .ex_eip        (ex_eip),
        .wbaq_full     (wbaq_full),
        .interrupt_in  (interrupt_in),
        .valid_out     (valid_out),
        .stall         (stall),
        .reg_ld        (reg_ld),
        .reg_addr      (reg_addr),
        .seg_ld        (seg_ld),
        .seg_addr      (seg_addr),
        .res           (res),
        .mem_ld        (mem_ld),
        .mem_addr      (mem_addr),
        .mem_data      (mem_data),
        .new_eip       (new_eip),
        .is_resteer    (is_resteer),
        .final_ie_val  (final_ie_val),
        .final_ie_type (final_ie_type),
        .wb_fwd_en     (wb_fwd_en),
        .wb_fwd_idx    (wb_fwd_idx),
        .wb_fwd_data   (wb_fwd_data)
    );

    arch_reg_file u_arch_reg_file (
        .clk       (clk),
        .reset     (reset),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .reg_ld    (reg_ld),
        .reg_addr  (reg_addr),
        .res       (res),
        .seg_ld    (seg_ld),
        .seg_addr  (seg_addr)
    );

endmodule

`default_nettype wire

// ==== src/uop_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module uop_decode (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        in_valid,
    input  wire backend_pkg::uop_word_t      in_uop,
    input  wire logic [31:0]                 in_eip,
    input  wire logic                        stall,
    input  wire logic                        flush,
    output logic                             dec_valid,
    output backend_pkg::op_class_t           dec_class,
    output backend_pkg::uop_word_t           dec_uop,
    output logic [31:0]                      dec_eip
);

    backend_pkg::op_class_t in_class;

    // opcode to class, anything unknown goes to undef
    always_comb begin
        case (in_uop.alu_view.opcode)
            backend_pkg::op_add,
            backend_pkg::op_sub,
            backend_pkg::op_and,
            backend_pkg::op_xor: begin
                in_class = backend_pkg::alu;
            end
            backend_pkg::op_mov_seg: begin
                in_class = backend_pkg::seg;
            end
            backend_pkg::op_store: begin
                in_class = backend_pkg::store;
            end
            backend_pkg::op_jmp: begin
                in_class = backend_pkg::jmp;
            end
            default: begin
                in_class = backend_pkg::undef;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (flush) begin
            dec_valid <= 1'b0;          // drops the op taken at the resteer edge
        end else if (!stall) begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            dec_class <= in_class;
            dec_uop   <= in_uop;
            dec_eip   <= in_eip;
        end
    end

endmodule

`default_nettype wire

// ==== src/uop_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module uop_execute (
    input  wire logic                                 clk,
    input  wire logic                                 reset,
    input  wire logic                                 dec_valid,
    input  wire backend_pkg::op_class_t               dec_class,
    input  wire backend_pkg::uop_word_t               dec_uop,
    input  wire logic [31:0]                          dec_eip,
    input  wire logic                                 stall,
    input  wire logic                                 flush,
    output logic [backend_pkg::gpr_idx_w-1:0]         rd_idx_a,
    output logic [backend_pkg::gpr_idx_w-1:0]         rd_idx_b,
    input  wire logic [backend_pkg::data_w-1:0]       rd_data_a,
    input  wire logic [backend_pkg::data_w-1:0]       rd_data_b,
    input  wire logic                                 wb_fwd_en,
    input  wire logic [backend_pkg::gpr_idx_w-1:0]    wb_fwd_idx,
    input  wire logic [backend_pkg::data_w-1:0]       wb_fwd_data,
    output logic                                      ex_valid,
    output backend_pkg::op_class_t                    ex_class,
    output logic [backend_pkg::gpr_idx_w-1:0]         ex_dst,
    output logic [backend_pkg::data_w-1:0]            ex_result,
    output logic [backend_pkg::data_w-1:0]            ex_addr,
    output logic [31:0]                               ex_target,
    output logic [31:0]                               ex_eip
);

    logic [backend_pkg::data_w-1:0] op_a;
    logic [backend_pkg::data_w-1:0] op_b;
    logic [backend_pkg::data_w-1:0] alu_res;
    logic [backend_pkg::data_w-1:0] next_result;
    logic [31:0]                    disp_ext;

    assign rd_idx_a = dec_uop.alu_view.src_a;
    assign rd_idx_b = dec_uop.alu_view.src_b;

    // writeback retires the op ahead at this same edge
    assign op_a = (wb_fwd_en && wb_fwd_idx == rd_idx_a) ? wb_fwd_data : rd_data_a;
    assign op_b = (wb_fwd_en && wb_fwd_idx == rd_idx_b) ? wb_fwd_data : rd_data_b;

    always_comb begin
        case (dec_uop.alu_view.opcode)
            backend_pkg::op_add: alu_res = op_a + op_b;
            backend_pkg::op_sub: alu_res = op_a - op_b;
            backend_pkg::op_and: alu_res = op_a & op_b;
            backend_pkg::op_xor: alu_res = op_a ^ op_b;
            default:             alu_res = '0;
        endcase
    end

    always_comb begin
        case (dec_class)
            backend_pkg::seg: begin
                next_result = {{(backend_pkg::data_w - backend_pkg::seg_w){1'b0}},
                               op_a[backend_pkg::seg_w-1:0]};
            end
            backend_pkg::store: begin
                next_result = op_b;     // store data
            end
            default: begin
                next_result = alu_res;
            end
        endcase
    end

    assign disp_ext = {{(32 - backend_pkg::disp_w){dec_uop.br_view.disp[backend_pkg::disp_w-1]}},
                       dec_uop.br_view.disp};

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;
        end else if (!stall) begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_class  <= dec_class;
            ex_dst    <= dec_uop.alu_view.dst;
            ex_result <= next_result;
            ex_addr   <= op_a;          // store address
            ex_target <= dec_eip + disp_ext;
            ex_eip    <= dec_eip;
        end
    end

endmodule

`default_nettype wire

// ==== writeback/arch_reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module arch_reg_file (
    input  wire logic                                 clk,
    input  wire logic                                 reset,
    input  wire logic [backend_pkg::gpr_idx_w-1:0]    rd_idx_a,
    input  wire logic [backend_pkg::gpr_idx_w-1:0]    rd_idx_b,
    output logic [backend_pkg::data_w-1:0]            rd_data_a,
    output logic [backend_pkg::data_w-1:0]            rd_data_b,
    input  wire logic                                 reg_ld,
    input  wire logic [backend_pkg::gpr_idx_w-1:0]    reg_addr,
    input  wire logic [backend_pkg::data_w-1:0]       res,
    input  wire logic                                 seg_ld,
    input  wire logic [backend_pkg::gpr_idx_w-1:0]    seg_addr
);

    logic [backend_pkg::data_w-1:0] gpr [backend_pkg::gpr_count];
    logic [backend_pkg::seg_w-1:0]  sreg [backend_pkg::seg_count];   // architectural only

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < backend_pkg::gpr_count; i++) begin
                gpr[i] <= '0;
            end
            for (int j = 0; j < backend_pkg::seg_count; j++) begin
                sreg[j] <= '0;
            end
        end else begin
            if (reg_ld) begin
                gpr[reg_addr] <= res;
            end
            if (seg_ld && seg_addr < backend_pkg::gpr_idx_w'(backend_pkg::seg_count)) begin
                sreg[seg_addr] <= res[backend_pkg::seg_w-1:0];
            end
        end
    end

    assign rd_data_a = gpr[rd_idx_a];
    assign rd_data_b = gpr[rd_idx_b];

endmodule

`default_nettype wire

// ==== writeback/writeback_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module writeback_stage (
    input  wire logic                                 ex_valid,
    input  wire backend_pkg::op_class_t               ex_class,
    input  wire logic [backend_pkg::gpr_idx_w-1:0]    ex_dst,
    input  wire logic [backend_pkg::data_w-1:0]       ex_result,
    input  wire logic [backend_pkg::data_w-1:0]       ex_addr,
    input  wire logic [31:0]                          ex_target,
    input  wire logic [31:0]                          ex_eip,
    input  wire logic                                 wbaq_full,
    input  wire logic                                 interrupt_in,
    output logic                                      valid_out,
    output logic                                      stall,
    output logic                                      reg_ld,
    output logic [backend_pkg::gpr_idx_w-1:0]         reg_addr,
    output logic                                      seg_ld,
    output logic [backend_pkg::gpr_idx_w-1:0]         seg_addr,
    output logic [backend_pkg::data_w-1:0]            res,
    output logic                                      mem_ld,
    output logic [backend_pkg::data_w-1:0]            mem_addr,
    output logic [backend_pkg::data_w-1:0]            mem_data,
    output logic [31:0]                               new_eip,
    output logic                                      is_resteer,
    output logic                                      final_ie_val,
    output logic [backend_pkg::ie_type_w-1:0]         final_ie_type,
    output logic                                      wb_fwd_en,
    output logic [backend_pkg::gpr_idx_w-1:0]         wb_fwd_idx,
    output logic [backend_pkg::data_w-1:0]            wb_fwd_data
);

    logic is_alu;
    logic is_seg;
    logic is_store;
    logic is_jmp;
    logic seg_bad;
    logic is_undef;
    logic undef_ie;

    assign is_alu   = ex_class == backend_pkg::alu;
    assign is_seg   = ex_class == backend_pkg::seg;
    assign is_store = ex_class == backend_pkg::store;
    assign is_jmp   = ex_class == backend_pkg::jmp;

    // only six segment registers exist
    assign seg_bad  = is_seg && (ex_dst >= backend_pkg::gpr_idx_w'(backend_pkg::seg_count));
    assign is_undef = (ex_class == backend_pkg::undef) || seg_bad;

    // store queue backpressure
    assign stall     = ex_valid && is_store && wbaq_full;
    assign valid_out = ex_valid && !stall;

    assign reg_ld   = valid_out && is_alu;
    assign reg_addr = ex_dst;
    assign seg_ld   = valid_out && is_seg && !seg_bad;
    assign seg_addr = ex_dst;
    assign res      = ex_result;

    assign mem_ld   = valid_out && is_store;
    assign mem_addr = ex_addr;
    assign mem_data = ex_result;

    // younger ops get flushed at the next edge
    assign is_resteer = valid_out && is_jmp;
    assign new_eip    = is_jmp ? ex_target : ex_eip;

    assign undef_ie     = valid_out && is_undef;
    assign final_ie_val = undef_ie || interrupt_in;

    always_comb begin
        final_ie_type = '0;
        if (undef_ie) begin
            final_ie_type[2:0] = backend_pkg::ie_undef_op[2:0];
        end
        final_ie_type[backend_pkg::ie_interrupt_bit] = interrupt_in;
    end

    // bypass to execute, same value the reg file takes at the edge
    assign wb_fwd_en   = reg_ld;
    assign wb_fwd_idx  = reg_addr;
    assign wb_fwd_data = res;

endmodule

`default_nettype wire
